/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int NUM_PORT    = 2;
    localparam int NUM_BANK    = 2;
    localparam int BANK_BITS   = 1;
    localparam int NUM_SET     = 16;
    localparam int SET_BITS    = 4;
    localparam int ADDR_W      = 12;
    localparam int DATA_W      = 32;
    localparam int TAG_W       = 4;
    localparam int PORT_W      = 1;
    localparam int QUEUE_DEPTH = 4;

    // word address with the bank in bit 0, the set above it and the cache tag on top
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  req_tag_t;
    typedef logic [PORT_W-1:0] port_id_t;

    // toward memory a set write bit is a writeback and a clear one a fill request
    typedef struct packed {
        logic     valid;
        logic     write;
        port_id_t port;
        req_tag_t req_tag;
        addr_t    addr;
        data_t    data;
    } cache_packet_t;

    typedef enum logic [2:0] {
        IDLE,
        RESPOND,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT
    } bank_state_t;

endpackage

`default_nettype wire

/* src/fifo_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_queue
    import cache_pkg::*;
#(
    parameter int DEPTH = QUEUE_DEPTH
)
(
    input  logic          clk_in,
    input  logic          rst,
    input  cache_packet_t push_packet,
    output logic          push_ack,
    output cache_packet_t head_packet,
    output logic          full,
    input  logic          issue_ack
);

    cache_packet_t            entry [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     push;
    logic                     pop;

    assign full        = count == DEPTH;
    assign push_ack    = !full;
    assign push        = push_packet.valid && !full;
    assign pop         = issue_ack && count != 0;
    assign head_packet = (count != 0) ? entry[rd_ptr] : '0;

    always_ff @(posedge clk_in)
    begin
        if (push)
            entry[wr_ptr] <= push_packet;
    end

    always_ff @(posedge clk_in)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // banks only ack a head they were shown as valid
    ack_needs_head: assert property (@(posedge clk_in) disable iff (rst)
        issue_ack |-> head_packet.valid)
        else $error("fifo_queue: issue ack while queue is empty");

endmodule

`default_nettype wire

/* src/priority_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module priority_arbiter
    import cache_pkg::*;
#(
    parameter int NUM_REQUEST = NUM_BANK
)
(
    input  cache_packet_t          request [NUM_REQUEST],
    input  logic [NUM_REQUEST-1:0] request_critical,
    output logic [NUM_REQUEST-1:0] issue_ack,
    output cache_packet_t          request_out,
    input  logic                   downstream_ack
);

    logic [NUM_REQUEST-1:0] grant;
    logic                   found;

    always_comb
    begin
        grant = '0;
        found = 1'b0;
        // critical requests first and then the lowest index
        for (int i = 0; i < NUM_REQUEST; i++)
        begin
            if (!found && request[i].valid && request_critical[i])
            begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
        for (int i = 0; i < NUM_REQUEST; i++)
        begin
            if (!found && request[i].valid)
            begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    always_comb
    begin
        request_out = '0;
        for (int i = 0; i < NUM_REQUEST; i++)
        begin
            if (grant[i])
                request_out = request[i];
        end
    end

    assign issue_ack = grant & {NUM_REQUEST{downstream_ack}};

endmodule

`default_nettype wire

/* src/cache_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_bank
    import cache_pkg::*;
#(
    parameter int BANK_ID = 0
)
(
    input  logic                clk_in,
    input  logic                rst,
    input  cache_packet_t       input_request [NUM_PORT],
    input  logic [NUM_PORT-1:0] input_critical,
    output logic [NUM_PORT-1:0] input_ack,
    input  cache_packet_t       fetched_packet,
    output logic                fetch_ack,
    output cache_packet_t       mem_packet,
    output logic                mem_critical,
    input  logic                mem_ack,
    output cache_packet_t       return_packet,
    input  logic                return_ack
);

    typedef logic [SET_BITS-1:0]                  set_idx_t;
    typedef logic [ADDR_W-SET_BITS-BANK_BITS-1:0] line_tag_t;

    line_tag_t          tag_mem  [NUM_SET];
    data_t              data_mem [NUM_SET];
    logic [NUM_SET-1:0] line_valid;
    logic [NUM_SET-1:0] line_dirty;

    bank_state_t        state;
    cache_packet_t      req_q;
    cache_packet_t      ret_q;

    cache_packet_t      sel_req;
    logic               sel_found;
    set_idx_t           sel_set;
    line_tag_t          sel_tag;
    logic               sel_hit;
    set_idx_t           req_set;

    logic               arr_we;
    set_idx_t           arr_set;
    line_tag_t          arr_tag;
    data_t              arr_data;
    cache_packet_t      resp_packet;

    // one request per cycle with critical first and then port 0
    always_comb
    begin
        sel_req   = '0;
        input_ack = '0;
        sel_found = 1'b0;
        if (state == IDLE)
        begin
            for (int p = 0; p < NUM_PORT; p++)
            begin
                if (!sel_found && input_request[p].valid && input_critical[p])
                begin
                    sel_req      = input_request[p];
                    input_ack[p] = 1'b1;
                    sel_found    = 1'b1;
                end
            end
            for (int p = 0; p < NUM_PORT; p++)
            begin
                if (!sel_found && input_request[p].valid)
                begin
                    sel_req      = input_request[p];
                    input_ack[p] = 1'b1;
                    sel_found    = 1'b1;
                end
            end
        end
    end

    assign sel_set   = sel_req.addr[SET_BITS+BANK_BITS-1:BANK_BITS];
    assign sel_tag   = sel_req.addr[ADDR_W-1:SET_BITS+BANK_BITS];
    assign sel_hit   = line_valid[sel_set] && tag_mem[sel_set] == sel_tag;
    assign req_set   = req_q.addr[SET_BITS+BANK_BITS-1:BANK_BITS];
    assign fetch_ack = state == FILL_WAIT && fetched_packet.valid;

    // line update on a write hit while idle or on a fill install
    always_comb
    begin
        if (state == FILL_WAIT)
        begin
            arr_we   = fetch_ack;
            arr_set  = req_set;
            arr_tag  = req_q.addr[ADDR_W-1:SET_BITS+BANK_BITS];
            arr_data = req_q.write ? req_q.data : fetched_packet.data;
        end
        else
        begin
            arr_we   = sel_found && sel_hit && sel_req.write;
            arr_set  = sel_set;
            arr_tag  = sel_tag;
            arr_data = sel_req.data;
        end
    end

    always_comb
    begin
        resp_packet       = (state == FILL_WAIT) ? req_q : sel_req;
        resp_packet.valid = 1'b1;
        if (state != FILL_WAIT && !sel_req.write)
            resp_packet.data = data_mem[sel_set];
        else
            resp_packet.data = arr_data;
    end

    // victim address is rebuilt from the stored tag
    always_comb
    begin
        mem_packet         = '0;
        mem_packet.port    = req_q.port;
        mem_packet.req_tag = req_q.req_tag;
        if (state == WRITEBACK)
        begin
            mem_packet.valid = 1'b1;
            mem_packet.write = 1'b1;
            mem_packet.addr  = {tag_mem[req_set], req_set, req_q.addr[BANK_BITS-1:0]};
            mem_packet.data  = data_mem[req_set];
        end
        else if (state == FILL_REQ)
        begin
            mem_packet.valid = 1'b1;
            mem_packet.addr  = req_q.addr;
        end
    end

    assign mem_critical  = state == WRITEBACK;
    assign return_packet = ret_q;

    always_ff @(posedge clk_in)
    begin
        if (arr_we)
        begin
            tag_mem[arr_set]  <= arr_tag;
            data_mem[arr_set] <= arr_data;
        end
        if (sel_found)
            req_q <= sel_req;
    end

    always_ff @(posedge clk_in)
    begin
        if (rst)
        begin
            state      <= IDLE;
            line_valid <= '0;
            line_dirty <= '0;
            ret_q      <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (sel_found)
                    begin
                        if (sel_hit)
                        begin
                            ret_q <= resp_packet;
                            if (sel_req.write)
                                line_dirty[sel_set] <= 1'b1;
                            state <= RESPOND;
                        end
                        else if (line_valid[sel_set] && line_dirty[sel_set])
                            state <= WRITEBACK;
                        else
                            state <= FILL_REQ;
                    end
                WRITEBACK:
                    if (mem_ack)
                        state <= FILL_REQ;
                FILL_REQ:
                    if (mem_ack)
                        state <= FILL_WAIT;
                FILL_WAIT:
                    if (fetch_ack)
                    begin
                        line_valid[req_set] <= 1'b1;
                        line_dirty[req_set] <= req_q.write;
                        ret_q               <= resp_packet;
                        state               <= RESPOND;
                    end
                RESPOND:
                    if (return_ack)
                    begin
                        ret_q.valid <= 1'b0;
                        state       <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // steering at the top must match this bank
    bank_select: assert property (@(posedge clk_in) disable iff (rst)
        |input_ack |-> sel_req.addr[BANK_BITS-1:0] == BANK_ID)
        else $error("cache_bank: accepted request for another bank");

    fill_in_wait: assert property (@(posedge clk_in) disable iff (rst)
        fetched_packet.valid |-> state == FILL_WAIT && fetched_packet.addr == req_q.addr)
        else $error("cache_bank: fill arrived without a matching miss");

endmodule

`default_nettype wire

/* src/unified_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module unified_cache
    import cache_pkg::*;
(
    input  logic                clk_in,
    input  logic                rst,
    input  cache_packet_t       input_packet [NUM_PORT],
    output logic [NUM_PORT-1:0] input_packet_ack,
    output cache_packet_t       return_packet [NUM_PORT],
    input  logic [NUM_PORT-1:0] return_packet_ack,
    input  cache_packet_t       from_mem_packet,
    output logic                from_mem_ack,
    output cache_packet_t       to_mem_packet,
    input  logic                to_mem_ack
);

    cache_packet_t       queue_head [NUM_PORT];
    logic [NUM_PORT-1:0] queue_full;
    logic [NUM_PORT-1:0] queue_issue_ack;

    logic [NUM_PORT-1:0] bank_input_ack [NUM_BANK];
    logic [NUM_BANK-1:0] bank_fetch_ack;
    cache_packet_t       bank_mem_packet [NUM_BANK];
    logic [NUM_BANK-1:0] bank_mem_critical;
    logic [NUM_BANK-1:0] bank_mem_ack;
    cache_packet_t       bank_return [NUM_BANK];
    logic [NUM_BANK-1:0] bank_return_ack;

    cache_packet_t       port_return [NUM_PORT][NUM_BANK];
    logic [NUM_BANK-1:0] port_return_ack [NUM_PORT];

    for (genvar p = 0; p < NUM_PORT; p++)
    begin : g_port
        fifo_queue #(.DEPTH(QUEUE_DEPTH)) u_input_queue
        (
            .clk_in      (clk_in),
            .rst         (rst),
            .push_packet (input_packet[p]),
            .push_ack    (input_packet_ack[p]),
            .head_packet (queue_head[p]),
            .full        (queue_full[p]),
            .issue_ack   (queue_issue_ack[p])
        );
    end

    for (genvar b = 0; b < NUM_BANK; b++)
    begin : g_bank
        cache_packet_t bank_request [NUM_PORT];
        cache_packet_t bank_fetch;

        // other banks see an all-zero packet
        for (genvar p = 0; p < NUM_PORT; p++)
        begin : g_steer
            assign bank_request[p] =
                (queue_head[p].addr[BANK_BITS-1:0] == b) ? queue_head[p] : '0;
        end
        assign bank_fetch =
            (from_mem_packet.addr[BANK_BITS-1:0] == b) ? from_mem_packet : '0;

        cache_bank #(.BANK_ID(b)) u_bank
        (
            .clk_in         (clk_in),
            .rst            (rst),
            .input_request  (bank_request),
            .input_critical (queue_full),
            .input_ack      (bank_input_ack[b]),
            .fetched_packet (bank_fetch),
            .fetch_ack      (bank_fetch_ack[b]),
            .mem_packet     (bank_mem_packet[b]),
            .mem_critical   (bank_mem_critical[b]),
            .mem_ack        (bank_mem_ack[b]),
            .return_packet  (bank_return[b]),
            .return_ack     (bank_return_ack[b])
        );
    end

    always_comb
    begin
        queue_issue_ack = '0;
        bank_return_ack = '0;
        for (int b = 0; b < NUM_BANK; b++)
        begin
            queue_issue_ack |= bank_input_ack[b];
            for (int p = 0; p < NUM_PORT; p++)
                bank_return_ack[b] |= port_return_ack[p][b];
        end
    end

    assign from_mem_ack = |bank_fetch_ack;

    // writebacks are critical and drain ahead of fills
    priority_arbiter #(.NUM_REQUEST(NUM_BANK)) mem_arbiter
    (
        .request          (bank_mem_packet),
        .request_critical (bank_mem_critical),
        .issue_ack        (bank_mem_ack),
        .request_out      (to_mem_packet),
        .downstream_ack   (to_mem_ack)
    );

    for (genvar p = 0; p < NUM_PORT; p++)
    begin : g_return
        for (genvar b = 0; b < NUM_BANK; b++)
        begin : g_filter
            assign port_return[p][b] = (bank_return[b].port == p) ? bank_return[b] : '0;
        end

        priority_arbiter #(.NUM_REQUEST(NUM_BANK)) return_arbiter
        (
            .request          (port_return[p]),
            .request_critical ('0),
            .issue_ack        (port_return_ack[p]),
            .request_out      (return_packet[p]),
            .downstream_ack   (return_packet_ack[p])
        );
    end

endmodule

`default_nettype wire

/* testbench/tb_unified_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_unified_cache
    import cache_pkg::*;
();

    localparam int    TIMEOUT     = 2000;
    localparam int    NUM_WORD    = 1 << ADDR_W;
    localparam int    NUM_TAG     = 1 << TAG_W;
    localparam int    PORT_SPAN   = NUM_WORD / NUM_PORT;
    localparam int    PH_RANDOM   = 0;
    localparam int    PH_HAMMER   = 1;
    localparam int    PH_READBACK = 2;
    localparam int    PH_DRAIN    = 3;
    localparam data_t INIT_KEY    = 32'h3c5a_0000;

    logic                clk_in = 1'b0;
    logic                rst;
    cache_packet_t       input_packet [NUM_PORT];
    logic [NUM_PORT-1:0] input_packet_ack;
    cache_packet_t       return_packet [NUM_PORT];
    logic [NUM_PORT-1:0] return_packet_ack;
    cache_packet_t       from_mem_packet;
    logic                from_mem_ack;
    cache_packet_t       to_mem_packet;
    logic                to_mem_ack;

    logic [31:0]         seed;
    int                  errors;
    int                  checks;
    int                  cycles;

    // architectural view and the memory behind the cache
    data_t               ref_mem [NUM_WORD];
    data_t               mem_store [NUM_WORD];
    logic [NUM_WORD-1:0] written;

    // outstanding requests per port and tag
    logic                pend_valid [NUM_PORT][NUM_TAG];
    logic                pend_write [NUM_PORT][NUM_TAG];
    logic                pend_fresh [NUM_PORT][NUM_TAG];
    addr_t               pend_addr [NUM_PORT][NUM_TAG];
    data_t               pend_data [NUM_PORT][NUM_TAG];
    req_tag_t            next_tag [NUM_PORT];
    int                  rb_idx [NUM_PORT];
    logic [NUM_PORT-1:0] in_fire;

    // one fill slot per bank as a bank has one miss at most
    logic                fill_pend [NUM_BANK];
    int                  fill_wait [NUM_BANK];
    cache_packet_t       fill_req [NUM_BANK];
    logic                fill_fire;

    always #5 clk_in = ~clk_in;

    unified_cache DUT
    (
        .clk_in            (clk_in),
        .rst               (rst),
        .input_packet      (input_packet),
        .input_packet_ack  (input_packet_ack),
        .return_packet     (return_packet),
        .return_packet_ack (return_packet_ack),
        .from_mem_packet   (from_mem_packet),
        .from_mem_ack      (from_mem_ack),
        .to_mem_packet     (to_mem_packet),
        .to_mem_ack        (to_mem_ack)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t init_word(input addr_t a);
        return INIT_KEY ^ data_t'(a);
    endfunction

    function automatic string test_name(input logic write, input logic fresh);
        if (write)
            return "write_echo";
        else if (fresh)
            return "read_init";
        else
            return "read_after_write";
    endfunction

    // port in bit 11 plus two tag bits, one set bit and the bank bit
    function automatic addr_t pool_addr(input int p, input logic [31:0] r, input logic hammer);
        addr_t a;
        a      = addr_t'(p * PORT_SPAN);
        a[6:5] = r[1:0];
        a[1]   = r[2];
        a[0]   = hammer ? 1'b0 : r[3];
        return a;
    endfunction

    function automatic logic readback_next(input int p, output addr_t a);
        a = '0;
        while (rb_idx[p] < PORT_SPAN)
        begin
            a = addr_t'(p * PORT_SPAN + rb_idx[p]);
            rb_idx[p]++;
            if (written[a])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic readback_done();
        logic done;
        done = 1'b1;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (rb_idx[p] < PORT_SPAN)
                done = 1'b0;
        end
        return done;
    endfunction

    function automatic int count_outstanding();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (input_packet[p].valid)
                n++;
            for (int t = 0; t < NUM_TAG; t++)
            begin
                if (pend_valid[p][t])
                    n++;
            end
        end
        return n;
    endfunction

    task automatic drive_inputs(input int phase);
        cache_packet_t pkt;
        addr_t         a;
        logic          go;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (in_fire[p])
                input_packet[p] = '0;
            seed = xorshift(seed);
            go   = 1'b0;
            a    = '0;
            pkt  = '0;
            if (!input_packet[p].valid && !pend_valid[p][next_tag[p]])
            begin
                case (phase)
                    PH_RANDOM:
                    begin
                        go        = seed[8];
                        a         = pool_addr(p, seed, 1'b0);
                        pkt.write = seed[9];
                    end
                    PH_HAMMER:
                    begin
                        go        = 1'b1;
                        a         = pool_addr(p, seed, 1'b1);
                        pkt.write = seed[9];
                    end
                    PH_READBACK:
                        go = readback_next(p, a);
                    default:
                        go = 1'b0;
                endcase
            end
            if (go)
            begin
                pkt.valid       = 1'b1;
                pkt.port        = port_id_t'(p);
                pkt.req_tag     = next_tag[p];
                pkt.addr        = a;
                pkt.data        = pkt.write ? xorshift(seed ^ 32'h9e37) : '0;
                input_packet[p] = pkt;
                next_tag[p]     = next_tag[p] + 1'b1;
            end
        end
    endtask

    // hammer phase holds returns back hard so the queues fill up
    task automatic drive_acks(input int phase);
        seed = xorshift(seed);
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (phase == PH_HAMMER)
                return_packet_ack[p] = seed[2*p] && seed[2*p+1];
            else if (phase == PH_RANDOM)
                return_packet_ack[p] = seed[2*p];
            else
                return_packet_ack[p] = seed[2*p] || seed[2*p+1];
        end
        if (phase == PH_RANDOM || phase == PH_HAMMER)
            to_mem_ack = seed[4];
        else
            to_mem_ack = seed[4] || seed[5];
    endtask

    task automatic drive_memory();
        if (fill_fire)
            from_mem_packet = '0;
        for (int b = 0; b < NUM_BANK; b++)
        begin
            if (fill_pend[b] && fill_wait[b] > 0)
                fill_wait[b]--;
            if (fill_pend[b] && fill_wait[b] == 0 && !from_mem_packet.valid)
            begin
                from_mem_packet      = fill_req[b];
                from_mem_packet.data = mem_store[fill_req[b].addr];
                fill_pend[b]         = 1'b0;
            end
        end
    endtask

    // expected data is fixed when the queue takes the request
    task automatic record_issue(input int p, input cache_packet_t pkt);
        pend_valid[p][pkt.req_tag] = 1'b1;
        pend_write[p][pkt.req_tag] = pkt.write;
        pend_addr[p][pkt.req_tag]  = pkt.addr;
        pend_fresh[p][pkt.req_tag] = !written[pkt.addr];
        if (pkt.write)
        begin
            ref_mem[pkt.addr] = pkt.data;
            written[pkt.addr] = 1'b1;
        end
        pend_data[p][pkt.req_tag] = ref_mem[pkt.addr];
    endtask

    task automatic check_return(input int p, input cache_packet_t pkt);
        req_tag_t t;
        string    name;
        t = pkt.req_tag;
        checks++;
        assert (pkt.port == port_id_t'(p))
        else
        begin
            errors++;
            $display("port %0d got a response that belongs to port %0d", p, pkt.port);
        end
        assert (pend_valid[p][t])
        else
        begin
            errors++;
            $display("port %0d got tag %0d, which is unknown or already answered", p, t);
        end
        if (pend_valid[p][t])
        begin
            name = test_name(pend_write[p][t], pend_fresh[p][t]);
            assert (pkt.write == pend_write[p][t])
            else
            begin
                errors++;
                $display("ERROR %s write flag, port %0d tag %0d: expected %0b, actual %0b",
                         name, p, t, pend_write[p][t], pkt.write);
            end
            assert (pkt.addr == pend_addr[p][t])
            else
            begin
                errors++;
                $display("ERROR %s address, port %0d tag %0d: expected %h, actual %h",
                         name, p, t, pend_addr[p][t], pkt.addr);
            end
            assert (pkt.data == pend_data[p][t])
            else
            begin
                errors++;
                $display("ERROR %s data at %h, port %0d tag %0d: expected %h, actual %h",
                         name, pend_addr[p][t], p, t, pend_data[p][t], pkt.data);
            end
            pend_valid[p][t] = 1'b0;
        end
    endtask

    task automatic sample_handshakes();
        int b;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            in_fire[p] = input_packet[p].valid && input_packet_ack[p];
            if (in_fire[p])
                record_issue(p, input_packet[p]);
            if (return_packet[p].valid && return_packet_ack[p])
                check_return(p, return_packet[p]);
        end
        fill_fire = from_mem_packet.valid && from_mem_ack;
        if (to_mem_packet.valid && to_mem_ack)
        begin
            if (to_mem_packet.write)
                mem_store[to_mem_packet.addr] = to_mem_packet.data;
            else
            begin
                b = int'(to_mem_packet.addr[BANK_BITS-1:0]);
                assert (!fill_pend[b])
                else
                begin
                    errors++;
                    $display("bank %0d asked for a second fill while one was pending", b);
                end
                seed         = xorshift(seed);
                fill_req[b]  = to_mem_packet;
                fill_wait[b] = 1 + int'(seed % 6);
                fill_pend[b] = 1'b1;
            end
        end
    endtask

    // drive after the falling edge and sample once everything has settled
    task automatic run_cycle(input int phase);
        @(negedge clk_in);
        drive_inputs(phase);
        drive_acks(phase);
        drive_memory();
        #2;
        sample_handshakes();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (count_outstanding() != 0 && n < TIMEOUT)
        begin
            run_cycle(PH_DRAIN);
            n++;
        end
        for (int p = 0; p < NUM_PORT; p++)
        begin
            assert (!input_packet[p].valid)
            else
            begin
                errors++;
                $display("timeout: port %0d request was never accepted", p);
            end
            for (int t = 0; t < NUM_TAG; t++)
            begin
                assert (!pend_valid[p][t])
                else
                begin
                    errors++;
                    $display("timeout: port %0d tag %0d at %h was never answered",
                             p, t, pend_addr[p][t]);
                end
            end
        end
    endtask

    initial
    begin
        seed            = 32'h5f67;
        errors          = 0;
        checks          = 0;
        rst             = 1'b1;
        written         = '0;
        in_fire         = '0;
        fill_fire       = 1'b0;
        from_mem_packet = '0;
        to_mem_ack      = 1'b0;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            input_packet[p]      = '0;
            return_packet_ack[p] = 1'b0;
            next_tag[p]          = '0;
            rb_idx[p]            = 0;
            for (int t = 0; t < NUM_TAG; t++)
                pend_valid[p][t] = 1'b0;
        end
        for (int b = 0; b < NUM_BANK; b++)
        begin
            fill_pend[b] = 1'b0;
            fill_wait[b] = 0;
            fill_req[b]  = '0;
        end
        for (int a = 0; a < NUM_WORD; a++)
        begin
            ref_mem[a]   = init_word(addr_t'(a));
            mem_store[a] = ref_mem[a];
        end

        repeat (3) @(negedge clk_in);
        rst = 1'b0;

        for (int i = 0; i < 600; i++)
            run_cycle(PH_RANDOM);
        // both ports on bank 0 with returns held back
        for (int i = 0; i < 300; i++)
            run_cycle(PH_HAMMER);
        drain();

        cycles = 0;
        while (!readback_done() && cycles < TIMEOUT)
        begin
            run_cycle(PH_READBACK);
            cycles++;
        end
        assert (readback_done())
        else
        begin
            errors++;
            $display("timeout while issuing the final readback reads");
        end
        drain();

        assert (checks > 0)
        else
        begin
            errors++;
            $display("no response was ever returned");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/cache_pkg.sv
src/fifo_queue.sv
src/priority_arbiter.sv
src/cache_bank.sv
src/unified_cache.sv
testbench/tb_unified_cache.sv

/* Bender.yml */
package:
  name: unified_cache

sources:
  - src/cache_pkg.sv
  - src/fifo_queue.sv
  - src/priority_arbiter.sv
  - src/cache_bank.sv
  - src/unified_cache.sv
  - target: simulation
    files:
      - testbench/tb_unified_cache.sv
